//--- Makefile
VERILATOR ?= verilator
TOP       ?= asg_tb
FLIST     ?= asg.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not complete"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- asg.f
source/asg_pkg.sv
source/asg_buffer.sv
source/asg_engine.sv
source/asg_linear.sv
source/asg_regs.sv
source/asg_top.sv
verif/asg_tb.sv

//--- source/asg_buffer.sv
// waveform table, 2**CWM signed samples
// port A serves the register bus, port B feeds the sample stream

`timescale 1ns/1ps
`default_nettype none

module asg_buffer #(
  parameter int unsigned CWM = 10,
  parameter int unsigned DWO = 14
) (
  input  logic            bus,
  input  logic            arst_n,
  // cpu port
  input  logic            wen,
  input  logic            ren,
  input  logic [CWM-1:0]  addr,
  input  logic [DWO-1:0]  wdata,
  output logic [DWO-1:0]  rdata,
  // engine port
  input  logic [CWM-1:0]  rd_addr,
  input  logic            rd_en,
  output asg_pkg::smp_t   smp
);

  logic [DWO-1:0] mem [2**CWM];
  logic [DWO-1:0] dat_q;  // port B data
  logic           vld_q;  // follows rd_en by one cycle

  // port A, write and synchronous read
  always_ff @(posedge bus) begin
    if (wen) mem[addr] <= wdata;
    if (ren) rdata <= mem[addr];   // old data on same cycle write
  end

  // port B, engine read
  always_ff @(posedge bus) begin
    if (rd_en) dat_q <= mem[rd_addr];
  end

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) vld_q <= 1'b0;
    else         vld_q <= rd_en;
  end

  assign smp = '{vld: vld_q, dat: dat_q};

endmodule

`default_nettype wire

//--- source/asg_engine.sv
// read pointer engine of the generator channel
// fixed point phase accumulator, CWM integer and CWF fraction bits,
// continuous wrap or repeated bursts of data and delay cycles

`timescale 1ns/1ps
`default_nettype none

module asg_engine #(
  parameter int unsigned CWM = 10,
  parameter int unsigned CWF = 16
) (
  input  logic              bus,
  input  logic              arst_n,
  input  asg_pkg::asg_cfg_t cfg,
  input  logic              ctl_rst,   // abort run
  input  logic              trg,       // start request
  output logic              trg_out,   // pulse at run start
  output logic [CWM-1:0]    rd_addr,
  output logic              rd_en
);

  localparam int unsigned PW = CWM + CWF;

  typedef enum logic [1:0] {
    st_idle,
    st_run,   // continuous
    st_bdat,  // burst data cycles
    st_bdly   // burst delay cycles
  } state_t;

  state_t      state;
  logic [PW-1:0] ptr;       // phase accumulator
  logic [PW:0]   ptr_sum;   // one carry bit
  logic [PW-1:0] ptr_wrap;
  logic [PW-1:0] ptr_nxt;
  logic [15:0]   dcnt;      // data cycles left
  logic [31:0]   lcnt;      // delay cycles left
  logic [15:0]   rcnt;      // bursts left
  logic          burst_done;
  logic          burst_more;

  //////////////////////////////////////////////////////////////////////
  // pointer step and wrap
  //////////////////////////////////////////////////////////////////////

  assign ptr_sum  = {1'b0, ptr} + {1'b0, cfg.step};
  assign ptr_wrap = ptr_sum[PW-1:0] - cfg.size;  // valid when sum >= size
  assign ptr_nxt  = (ptr_sum >= {1'b0, cfg.size}) ? ptr_wrap : ptr_sum[PW-1:0];

  //////////////////////////////////////////////////////////////////////
  // burst bookkeeping
  //////////////////////////////////////////////////////////////////////

  // last data cycle with no delay, or last delay cycle
  assign burst_done = ((state == st_bdat) && (dcnt == '0) && (cfg.bdly == '0)) ||
                      ((state == st_bdly) && (lcnt == '0));

  assign burst_more = cfg.binf | (rcnt > 16'd1);  // bnum 0 acts as 1

  //////////////////////////////////////////////////////////////////////
  // fsm
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      state   <= st_idle;
      ptr     <= '0;
      dcnt    <= '0;
      lcnt    <= '0;
      rcnt    <= '0;
      trg_out <= 1'b0;
    end else begin
      trg_out <= 1'b0;
      if (ctl_rst) begin
        state <= st_idle;
      end else begin
        case (state)
          st_idle: begin
            if (trg) begin
              trg_out <= 1'b1;
              ptr     <= cfg.offs;
              dcnt    <= cfg.bcyc - 16'd1;
              rcnt    <= cfg.bnum;
              state   <= cfg.bena ? st_bdat : st_run;
            end
          end
          st_run: begin
            ptr <= ptr_nxt;      // until ctl_rst
          end
          st_bdat: begin
            ptr <= ptr_nxt;
            if (dcnt != '0) begin
              dcnt <= dcnt - 16'd1;
            end else if (cfg.bdly != '0) begin
              lcnt  <= cfg.bdly - 32'd1;
              state <= st_bdly;
            end
          end
          st_bdly: begin
            if (lcnt != '0) lcnt <= lcnt - 32'd1;
          end
          default: state <= st_idle;
        endcase

        // next burst restarts at offs, overrides the step above
        if (burst_done) begin
          if (burst_more) begin
            ptr   <= cfg.offs;
            dcnt  <= cfg.bcyc - 16'd1;
            rcnt  <= rcnt - 16'd1;
            state <= st_bdat;
          end else begin
            state <= st_idle;
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // table address
  //////////////////////////////////////////////////////////////////////

  assign rd_addr = ptr[PW-1:CWF];  // integer part
  assign rd_en   = (state == st_run) || (state == st_bdat);

endmodule

`default_nettype wire

//--- source/asg_linear.sv
// linear output stage, y = x * lmul / 2**(DWM-2) + lsum
// saturates to the signed DWO range, one cycle latency

`timescale 1ns/1ps
`default_nettype none

module asg_linear #(
  parameter int unsigned DWO = 14,
  parameter int unsigned DWM = 16
) (
  input  logic                  bus,
  input  logic                  arst_n,
  input  asg_pkg::smp_t         sti,
  output asg_pkg::smp_t         sto,
  input  logic signed [DWM-1:0] lmul,   // unity at 2**(DWM-2)
  input  logic signed [DWO-1:0] lsum
);

  localparam int unsigned PW = DWO + DWM;

  // signed DWO limits, extended to the sum width
  localparam logic signed [PW:0] sat_hi = {{(PW-DWO+2){1'b0}}, {(DWO-1){1'b1}}};
  localparam logic signed [PW:0] sat_lo = {{(PW-DWO+2){1'b1}}, {(DWO-1){1'b0}}};

  logic signed [DWO-1:0] dat_i;
  logic signed [PW-1:0]  mul;   // full product
  logic signed [PW-1:0]  shd;   // gain scaled back
  logic signed [PW:0]    sum;
  logic signed [DWO-1:0] sat;
  logic signed [DWO-1:0] dat_q;
  logic                  vld_q;

  assign dat_i = sti.dat;
  assign mul   = dat_i * lmul;
  assign shd   = mul >>> (DWM-2);   // arithmetic
  assign sum   = shd + lsum;

  always_comb begin
    if (sum > sat_hi)      sat = sat_hi[DWO-1:0];
    else if (sum < sat_lo) sat = sat_lo[DWO-1:0];
    else                   sat = sum[DWO-1:0];
  end

  always_ff @(posedge bus) begin
    if (sti.vld) dat_q <= sat;
  end

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) vld_q <= 1'b0;
    else         vld_q <= sti.vld;
  end

  assign sto = '{vld: vld_q, dat: dat_q};

endmodule

`default_nettype wire

//--- source/asg_pkg.sv
// shared types for the arbitrary signal generator channel
// bus request/response, stream beat, configuration bundle, register map
// struct widths follow the localparams below, which are also the top defaults

`default_nettype none

package asg_pkg;

  ////////////////////////////////////////////////////////////////////
  // default widths
  ////////////////////////////////////////////////////////////////////

  localparam int unsigned CWM = 10;  // pointer integer bits
  localparam int unsigned CWF = 16;  // pointer fraction bits
  localparam int unsigned DWO = 14;  // sample width
  localparam int unsigned DWM = 16;  // gain width
  localparam int unsigned TN  = 4;   // external trigger inputs

  ////////////////////////////////////////////////////////////////////
  // register bus
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic        wen;    // write strobe, one cycle
    logic        ren;    // read strobe, one cycle
    logic [31:0] addr;   // byte address
    logic [31:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic        ack;    // pulse one cycle after strobe
    logic        err;    // tied low
    logic [31:0] rdata;
  } bus_rsp_t;

  // sample stream, no back-pressure
  typedef struct packed {
    logic                  vld;
    logic signed [DWO-1:0] dat;
  } smp_t;

  // channel configuration
  typedef struct packed {
    logic [TN-1:0]         tsel;  // external trigger select mask
    logic                  bena;  // burst mode
    logic                  binf;  // endless bursts
    logic [CWM+CWF-1:0]    size;  // table length, fixed point
    logic [CWM+CWF-1:0]    offs;  // start phase
    logic [CWM+CWF-1:0]    step;  // phase increment
    logic [15:0]           bcyc;  // data cycles per burst
    logic [31:0]           bdly;  // delay cycles per burst
    logic [15:0]           bnum;  // burst repetitions
    logic signed [DWM-1:0] lmul;  // gain, unity at 2**(DWM-2)
    logic signed [DWO-1:0] lsum;  // offset
  } asg_cfg_t;

  // reset value, unity gain and all else cleared
  localparam asg_cfg_t cfg_def = '{lmul: 1 << (DWM-2), default: '0};

  ////////////////////////////////////////////////////////////////////
  // register offsets, low six address bits
  ////////////////////////////////////////////////////////////////////

  localparam logic [5:0] reg_ctl  = 6'h00;  // bit0 reset, bit1 sw trigger
  localparam logic [5:0] reg_cfg  = 6'h04;
  localparam logic [5:0] reg_size = 6'h08;
  localparam logic [5:0] reg_offs = 6'h0c;
  localparam logic [5:0] reg_step = 6'h10;
  localparam logic [5:0] reg_bcyc = 6'h18;
  localparam logic [5:0] reg_bdly = 6'h1c;
  localparam logic [5:0] reg_bnum = 6'h20;
  localparam logic [5:0] reg_lmul = 6'h24;
  localparam logic [5:0] reg_lsum = 6'h28;

endpackage

`default_nettype wire

//--- source/asg_regs.sv
// register bank and bus decoder of the generator channel
// splits the bus space into config registers and the waveform table,
// answers every access with a one cycle delayed ack

`timescale 1ns/1ps
`default_nettype none

module asg_regs #(
  parameter int unsigned CWM = 10,
  parameter int unsigned CWF = 16,
  parameter int unsigned DWO = 14,
  parameter int unsigned DWM = 16,
  parameter int unsigned TN  = 4
) (
  input  logic               bus,
  input  logic               arst_n,
  input  asg_pkg::bus_req_t  req,
  output asg_pkg::bus_rsp_t  rsp,
  output asg_pkg::asg_cfg_t  cfg,
  output logic               ctl_rst,    // pulse, same cycle as write
  output logic               trg_swo,    // pulse, same cycle as write
  output logic               buf_wen,
  output logic               buf_ren,
  output logic [CWM-1:0]     buf_addr,   // word index
  output logic [DWO-1:0]     buf_wdata,
  input  logic [DWO-1:0]     buf_rdata   // registered in the buffer
);

  import asg_pkg::*;

  logic        is_buf;     // table region select
  logic        reg_wen;
  logic        reg_ren;
  logic [5:0]  offs;       // register offset
  logic        ack_q;
  logic        sel_buf_q;  // last read went to the table
  logic [31:0] rdata_q;

  assign is_buf  = req.addr[CWM+2];
  assign offs    = req.addr[5:0];
  assign reg_wen = req.wen & ~is_buf;
  assign reg_ren = req.ren & ~is_buf;

  //////////////////////////////////////////////////////////////////////
  // control strobes and table access
  //////////////////////////////////////////////////////////////////////

  assign ctl_rst = reg_wen & (offs == reg_ctl) & req.wdata[0];
  assign trg_swo = reg_wen & (offs == reg_ctl) & req.wdata[1];

  assign buf_wen   = req.wen & is_buf;
  assign buf_ren   = req.ren & is_buf;
  assign buf_addr  = req.addr[2 +: CWM];
  assign buf_wdata = req.wdata[DWO-1:0];

  //////////////////////////////////////////////////////////////////////
  // configuration registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      cfg <= cfg_def;
    end else if (reg_wen) begin
      case (offs)
        reg_cfg: begin
          cfg.tsel <= req.wdata[TN-1:0];
          cfg.bena <= req.wdata[TN];
          cfg.binf <= req.wdata[TN+1];
        end
        reg_size: cfg.size <= req.wdata[CWM+CWF-1:0];
        reg_offs: cfg.offs <= req.wdata[CWM+CWF-1:0];
        reg_step: cfg.step <= req.wdata[CWM+CWF-1:0];
        reg_bcyc: cfg.bcyc <= req.wdata[15:0];
        reg_bdly: cfg.bdly <= req.wdata;
        reg_bnum: cfg.bnum <= req.wdata[15:0];
        reg_lmul: cfg.lmul <= req.wdata[DWM-1:0];
        reg_lsum: cfg.lsum <= req.wdata[DWO-1:0];
        default: ;  // ctl and holes hold no state
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      ack_q     <= 1'b0;
      sel_buf_q <= 1'b0;
    end else begin
      ack_q <= req.wen | req.ren;        // register or table, same latency
      if (req.ren) sel_buf_q <= is_buf;
    end
  end

  // register read mux, data only
  always_ff @(posedge bus) begin
    if (reg_ren) begin
      case (offs)
        reg_cfg:  rdata_q <= 32'({cfg.binf, cfg.bena, cfg.tsel});
        reg_size: rdata_q <= {{(32-CWM-CWF){1'b0}}, cfg.size};
        reg_offs: rdata_q <= {{(32-CWM-CWF){1'b0}}, cfg.offs};
        reg_step: rdata_q <= {{(32-CWM-CWF){1'b0}}, cfg.step};
        reg_bcyc: rdata_q <= {16'd0, cfg.bcyc};
        reg_bdly: rdata_q <= cfg.bdly;
        reg_bnum: rdata_q <= {16'd0, cfg.bnum};
        reg_lmul: rdata_q <= {{(32-DWM){cfg.lmul[DWM-1]}}, cfg.lmul};  // sign ext
        reg_lsum: rdata_q <= {{(32-DWO){cfg.lsum[DWO-1]}}, cfg.lsum};
        default:  rdata_q <= '0;  // unused offsets read zero
      endcase
    end
  end

  assign rsp = '{
    ack:   ack_q,
    err:   1'b0,
    rdata: sel_buf_q ? {{(32-DWO){buf_rdata[DWO-1]}}, buf_rdata} : rdata_q
  };

endmodule

`default_nettype wire

//--- source/asg_top.sv
// one arbitrary signal generator channel
// register bank, waveform table, pointer engine and gain/offset stage;
// the run starts on a software trigger or a selected external input

`timescale 1ns/1ps
`default_nettype none

module asg_top #(
  parameter int unsigned CWM = 10,  // pointer integer bits
  parameter int unsigned CWF = 16,  // pointer fraction bits
  parameter int unsigned DWO = 14,  // sample width
  parameter int unsigned DWM = 16,  // gain width
  parameter int unsigned TN  = 4    // external triggers
) (
  input  logic              bus,
  input  logic              arst_n,
  input  asg_pkg::bus_req_t req,
  output asg_pkg::bus_rsp_t rsp,
  input  logic [TN-1:0]     trg_ext,
  output logic              trg_swo,
  output logic              trg_out,
  output asg_pkg::smp_t     sto
);

  import asg_pkg::*;

  asg_cfg_t       cfg;
  logic           ctl_rst;
  logic           trg_mux;    // engine start
  logic           buf_wen;
  logic           buf_ren;
  logic [CWM-1:0] buf_addr;
  logic [DWO-1:0] buf_wdata;
  logic [DWO-1:0] buf_rdata;
  logic [CWM-1:0] rd_addr;
  logic           rd_en;
  smp_t           stg;        // raw table samples

  // selected external inputs or software
  assign trg_mux = (|(trg_ext & cfg.tsel)) | trg_swo;

  asg_regs #(.CWM(CWM), .CWF(CWF), .DWO(DWO), .DWM(DWM), .TN(TN)) i_regs (
    .bus(bus), .arst_n(arst_n), .req(req), .rsp(rsp), .cfg(cfg),
    .ctl_rst(ctl_rst), .trg_swo(trg_swo),
    .buf_wen(buf_wen), .buf_ren(buf_ren), .buf_addr(buf_addr),
    .buf_wdata(buf_wdata), .buf_rdata(buf_rdata)
  );

  asg_buffer #(.CWM(CWM), .DWO(DWO)) i_buffer (
    .bus(bus), .arst_n(arst_n),
    .wen(buf_wen), .ren(buf_ren), .addr(buf_addr), .wdata(buf_wdata), .rdata(buf_rdata),
    .rd_addr(rd_addr), .rd_en(rd_en), .smp(stg)
  );

  asg_engine #(.CWM(CWM), .CWF(CWF)) i_engine (
    .bus(bus), .arst_n(arst_n), .cfg(cfg), .ctl_rst(ctl_rst), .trg(trg_mux),
    .trg_out(trg_out), .rd_addr(rd_addr), .rd_en(rd_en)
  );

  asg_linear #(.DWO(DWO), .DWM(DWM)) i_linear (
    .bus(bus), .arst_n(arst_n), .sti(stg), .sto(sto),
    .lmul(cfg.lmul), .lsum(cfg.lsum)
  );

endmodule

`default_nettype wire

//--- verif/asg_tb.sv
// directed testbench for the signal generator channel
// drives the register bus, loads the waveform table and checks the sample
// stream against a model of the pointer, burst and gain/offset rules

`timescale 1ns/1ps
`default_nettype none

module asg_tb;

  import asg_pkg::*;

  localparam int unsigned unity = 1 << (DWM-2);                 // gain 1.0
  localparam int test_cycles = 10 + 100 + 130 + 100 + 80 + 120 + 80;  // reset and tests 1 to 6
  localparam int wd_cycles   = 2 * test_cycles + 200;

  logic          bus;
  logic          arst_n;
  bus_req_t      req;
  bus_rsp_t      rsp;
  logic [TN-1:0] trg_ext;
  logic          trg_swo;
  logic          trg_out;
  smp_t          sto;

  logic [DWO-1:0] tbl [2**CWM];   // what the tests wrote to the table
  logic [DWO-1:0] got_q [$];      // collected output samples
  logic [DWO-1:0] exp_q [$];
  int             stamp_q [$];    // cycle of each sample
  int             cyc;
  int             swo_cnt;
  int             out_cnt;
  int             err_mis;
  int             err_oth;
  int             seed = 18126;

  always #10 bus = ~bus;  // 20 ns period

  asg_top #(.CWM(CWM), .CWF(CWF), .DWO(DWO), .DWM(DWM), .TN(TN)) i_dut (
    .bus(bus), .arst_n(arst_n), .req(req), .rsp(rsp), .trg_ext(trg_ext),
    .trg_swo(trg_swo), .trg_out(trg_out), .sto(sto)
  );

  // sample on the falling edge where outputs have settled
  always @(negedge bus) begin
    if (arst_n) begin
      cyc++;
      if (sto.vld) begin
        got_q.push_back(sto.dat);
        stamp_q.push_back(cyc);
      end
      if (trg_swo) swo_cnt++;
      if (trg_out) out_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // checks and bus access
  ////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      err_mis++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      err_oth++;
      $display("error: %s", what);
    end
  endtask

  // called 1 ns after a rising edge and returns at the same phase
  task automatic bus_access(input logic wr, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    req.wen   = wr;
    req.ren   = ~wr;
    req.addr  = addr;
    req.wdata = wdata;
    @(posedge bus);
    #1;
    req.wen = 1'b0;
    req.ren = 1'b0;
    // ack and rdata due one cycle after the strobe
    check_true(rsp.ack, $sformatf("no ack one cycle after access at 0x%h", addr));
    check_value("rsp.err", 32'(rsp.err), 32'h0);
    rdata = rsp.rdata;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, addr, data, unused);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    bus_access(1'b0, addr, 32'h0, data);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge bus);
    #1;
  endtask

  function automatic logic [31:0] table_addr(input int idx);
    return (32'h1 << (CWM+2)) | (32'(idx) << 2);  // table region bit set
  endfunction

  function automatic logic [31:0] sign_extend(input logic [31:0] v, input int w);
    logic [31:0] m;
    m = (32'h1 << w) - 1;
    return v[w-1] ? (v | ~m) : (v & m);
  endfunction

  // register contents after a write masked to each field width
  function automatic logic [31:0] readback_value(input logic [5:0] offs, input logic [31:0] d);
    case (offs)
      reg_cfg:                      return d & ((32'h1 << (TN+2)) - 1);
      reg_size, reg_offs, reg_step: return d & ((32'h1 << (CWM+CWF)) - 1);
      reg_bcyc, reg_bnum:           return d & 32'hffff;
      reg_bdly:                     return d;
      reg_lmul:                     return sign_extend(d, DWM);
      reg_lsum:                     return sign_extend(d, DWO);
      default:                      return 32'h0;  // ctl and holes
    endcase
  endfunction

  task automatic load_entry(input int idx, input logic [31:0] data);
    bus_write(table_addr(idx), data);
    tbl[idx] = data[DWO-1:0];
  endtask

  task automatic configure(input logic [31:0] cfg_word, input int size, input int offs,
                           input int step, input int gain, input int ofs);
    bus_write(32'(reg_cfg), cfg_word);
    bus_write(32'(reg_size), 32'(size));
    bus_write(32'(reg_offs), 32'(offs));
    bus_write(32'(reg_step), 32'(step));
    bus_write(32'(reg_lmul), 32'(gain));
    bus_write(32'(reg_lsum), 32'(ofs));
  endtask

  task automatic clear_monitor();
    got_q.delete();
    stamp_q.delete();
    swo_cnt = 0;
    out_cnt = 0;
  endtask

  task automatic wait_samples(input int count, input int limit);
    int n;
    n = 0;
    while (got_q.size() < count && n < limit) begin
      @(posedge bus);
      #1;
      n++;
    end
    check_true(got_q.size() >= count, $sformatf("fewer than %0d samples arrived", count));
  endtask

  ////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////

  // gain in units of 2**(DWM-2) then offset and clamp to signed DWO
  function automatic logic [DWO-1:0] linear_model(input logic [DWO-1:0] raw, input int gain,
                                                   input int ofs);
    longint x;
    longint y;
    x = longint'($signed(raw));
    y = ((x * gain) >>> (DWM-2)) + ofs;
    if (y > (2**(DWO-1) - 1)) y = 2**(DWO-1) - 1;
    else if (y < -(2**(DWO-1))) y = -(2**(DWO-1));
    return y[DWO-1:0];
  endfunction

  // burst_len 0 means one continuous run
  task automatic fill_expected(input longint offs, input longint step, input longint size,
                               input int count, input int burst_len, input int gain,
                               input int ofs);
    longint ptr;
    int     idx;
    exp_q.delete();
    ptr = offs;
    for (int i = 0; i < count; i++) begin
      if (burst_len > 0 && i % burst_len == 0) ptr = offs;  // burst restart
      idx = int'(ptr >> CWF);                               // integer part
      exp_q.push_back(linear_model(tbl[idx], gain, ofs));
      ptr = ptr + step;
      if (ptr >= size) ptr = ptr - size;
    end
  endtask

  task automatic compare_samples(input int count);
    check_true(got_q.size() >= count, "sample queue shorter than the expected run");
    for (int i = 0; i < count && i < got_q.size(); i++)
      check_value($sformatf("sto.dat[%0d]", i), 32'(got_q[i]), 32'(exp_q[i]));
  endtask

  ////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////

  task automatic test_registers();
    logic [5:0]  regs [12];
    logic [31:0] pat [2];
    logic [31:0] rd;
    regs = '{reg_ctl, reg_cfg, reg_size, reg_offs, reg_step, 6'h14, reg_bcyc, reg_bdly,
             reg_bnum, reg_lmul, reg_lsum, 6'h2c};
    pat  = '{32'ha5a5_c3c3, 32'h5a5a_3c3c};  // both signs in lmul and lsum
    foreach (regs[i]) begin
      bus_read(32'(regs[i]), rd);
      check_value($sformatf("reset rdata at 0x%h", regs[i]), rd,
                  (regs[i] == reg_lmul) ? 32'(unity) : 32'h0);
    end
    foreach (pat[p]) begin
      for (int i = 1; i < 12; i++) bus_write(32'(regs[i]), pat[p]);  // ctl would start a run
      foreach (regs[i]) begin
        bus_read(32'(regs[i]), rd);
        check_value($sformatf("rdata at 0x%h", regs[i]), rd, readback_value(regs[i], pat[p]));
      end
    end
  endtask

  task automatic test_buffer();
    int          idx [32];
    logic [31:0] dat;
    logic [31:0] rd;
    foreach (idx[i]) begin
      idx[i] = $random(seed) & (2**CWM - 1);
      dat    = $random(seed);
      load_entry(idx[i], dat);
    end
    foreach (idx[i]) begin
      bus_read(table_addr(idx[i]), rd);
      check_value($sformatf("table[%0d]", idx[i]), rd, sign_extend(32'(tbl[idx[i]]), DWO));
    end
  endtask

  task automatic test_continuous();
    int n_stop;
    for (int i = 0; i < 8; i++) load_entry(i, $random(seed));
    configure(32'h0, 8 << CWF, 3 << CWF, 1 << CWF, unity, 0);
    clear_monitor();
    bus_write(32'(reg_ctl), 32'h2);  // sw trigger
    wait_samples(20, 60);
    bus_write(32'(reg_ctl), 32'h1);  // control reset
    wait_cycles(5);                  // pipeline drains
    n_stop = got_q.size();
    wait_cycles(20);
    check_value("valid count after control reset", got_q.size(), n_stop);
    check_value("trg_swo pulses", swo_cnt, 1);
    check_value("trg_out pulses", out_cnt, 1);
    fill_expected(3 << CWF, 1 << CWF, 8 << CWF, 20, 0, unity, 0);
    compare_samples(20);
  endtask

  task automatic pulse_ext(input int b);
    trg_ext[b] = 1'b1;
    @(posedge bus);
    #1;
    trg_ext = '0;
  endtask

  task automatic test_half_step();
    configure(32'h1 << 2, 8 << CWF, 0, 1 << (CWF-1), unity, 0);  // tsel bit 2
    clear_monitor();
    pulse_ext(0);  // not selected
    wait_cycles(10);
    check_value("valid count after unselected trigger", got_q.size(), 0);
    check_value("trg_out pulses after unselected trigger", out_cnt, 0);
    pulse_ext(2);
    wait_samples(24, 80);
    bus_write(32'(reg_ctl), 32'h1);
    wait_cycles(5);
    check_value("trg_out pulses", out_cnt, 1);
    fill_expected(0, 1 << (CWF-1), 8 << CWF, 24, 0, unity, 0);  // each entry twice
    compare_samples(24);
  endtask

  task automatic test_burst();
    int bcyc;
    int bdly;
    int bnum;
    bcyc = 5;
    bdly = 7;
    bnum = 3;
    configure(32'h1 << TN, 8 << CWF, 5 << CWF, 1 << CWF, unity, 0);  // bena with wrap at 8
    bus_write(32'(reg_bcyc), 32'(bcyc));
    bus_write(32'(reg_bdly), 32'(bdly));
    bus_write(32'(reg_bnum), 32'(bnum));
    clear_monitor();
    bus_write(32'(reg_ctl), 32'h2);
    wait_samples(bcyc * bnum, 100);
    wait_cycles(40);  // nothing more after the last burst
    check_value("valid count", got_q.size(), bcyc * bnum);
    check_value("trg_out pulses", out_cnt, 1);
    for (int i = 1; i < bcyc * bnum && i < stamp_q.size(); i++)
      check_value($sformatf("spacing before sample %0d", i), stamp_q[i] - stamp_q[i-1],
                  (i % bcyc == 0) ? bdly + 1 : 1);
    fill_expected(5 << CWF, 1 << CWF, 8 << CWF, bcyc * bnum, bcyc, unity, 0);
    compare_samples(bcyc * bnum);
    bus_write(32'(reg_cfg), 32'h0);
  endtask

  task automatic test_linear();
    int gain;
    int ofs;
    gain = 32'h7fff;  // 2.0 itself wraps negative in DWM bits
    ofs  = -300;
    for (int i = 0; i < 4; i++) load_entry(i, $random(seed) % 1024);
    load_entry(4, 32'h1fff);  // signed max
    load_entry(5, 32'h2000);  // signed min
    load_entry(6, 6000);
    load_entry(7, -5000);
    configure(32'h0, 8 << CWF, 0, 1 << CWF, gain, ofs);
    clear_monitor();
    bus_write(32'(reg_ctl), 32'h2);
    wait_samples(16, 60);
    bus_write(32'(reg_ctl), 32'h1);
    wait_cycles(5);
    fill_expected(0, 1 << CWF, 8 << CWF, 16, 0, gain, ofs);
    compare_samples(16);
  endtask

  ////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////////////

  initial begin
    bus     = 1'b0;
    arst_n  = 1'b0;
    req     = '0;
    trg_ext = '0;
    cyc     = 0;
    swo_cnt = 0;
    out_cnt = 0;
    err_mis = 0;
    err_oth = 0;
    repeat (10) @(posedge bus);
    #1;
    arst_n = 1'b1;
    check_true(!rsp.ack && !trg_out && !trg_swo && !sto.vld, "outputs active after reset");
    test_registers();
    test_buffer();
    test_continuous();
    test_half_step();
    test_burst();
    test_linear();
    $display("errors: %0d mismatches, %0d other failures", err_mis, err_oth);
    if (err_mis + err_oth == 0) $display("No errors");
    else $display("Errors found");
    $finish;
  end

  initial begin
    repeat (wd_cycles) @(posedge bus);
    $display("watchdog expired after %0d cycles, run stopped", wd_cycles);
    $display("errors: %0d mismatches, %0d other failures", err_mis, err_oth + 1);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire
